/* rtl/busSizePkg.sv */
// Shared size codes, DSACK terminations, port addresses and bus widths for the bus-sizing bridge
package busSizePkg;

    ////////////////////
    // CPU size codes
    ////////////////////

    // SIZ encoding as driven by the CPU
    localparam logic [1:0] sizeLword = 2'b00;   // Longword, four bytes
    localparam logic [1:0] sizeByte  = 2'b01;   // Single byte
    localparam logic [1:0] sizeWord  = 2'b10;   // Two bytes
    // Code 11 is a line transfer, not supported here
    // Decode folds it onto sizeLword

    ////////////////////
    // Port terminations
    ////////////////////

    // DSACK code returned by the slow port
    localparam logic [1:0] dsackLong = 2'b00;   // 32 bit port
    localparam logic [1:0] dsackWord = 2'b01;   // 16 bit port on the upper lanes
    localparam logic [1:0] dsackWait = 2'b11;   // Insert wait state
    // Byte termination (2'b10) stays disabled

    ////////////////////
    // Port address bits
    ////////////////////

    // Address bits 1:0 presented to the port
    localparam logic [1:0] portUpperWord = 2'b00;  // First or only cycle
    localparam logic [1:0] portLowerWord = 2'b10;  // Second half of a split longword

    ////////////////////
    // Bus widths
    ////////////////////

    // CPU and port data buses are both this wide
    localparam int cpuDataWidth = 32;

    // Word port moves this many bits per cycle
    // Must stay half of cpuDataWidth for the lane steering
    localparam int wordWidth = 16;

endpackage

/* rtl/cycleDecode.sv */
// CPU request capture: size folding, held attributes and the one-cycle start pulse
`timescale 1ns/1ps

module cycleDecode (
    input  logic                                BCLK,
    input  logic                                nRESET,
    input  logic                                nTsCpu,     // CPU transfer start, low for one cycle
    input  logic                                rnw,        // High for read
    input  logic [1:0]                          siz,
    input  logic [1:0]                          addr,       // Byte offset within the longword
    input  logic [busSizePkg::cpuDataWidth-1:0] cpuWrData,
    output logic                                reqStart,   // Pulse, request now held
    output logic                                reqWrite,
    output logic [1:0]                          reqSize,
    output logic [1:0]                          reqAddr,
    output logic [busSizePkg::cpuDataWidth-1:0] reqWrData
);

    ////////////////////
    // Size folding
    ////////////////////

    logic [1:0] sizeMapped;

    // Line code has no meaning without bursts
    always_comb begin
        case (siz)
            busSizePkg::sizeByte,
            busSizePkg::sizeWord: sizeMapped = siz;                 // Pass as is
            default:              sizeMapped = busSizePkg::sizeLword; // Longword and line
        endcase
    end

    ////////////////////
    // Request hold
    ////////////////////

    // Control attributes, cleared by reset
    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            reqStart <= 1'b0;
            reqWrite <= 1'b0;
            reqSize  <= busSizePkg::sizeLword;
            reqAddr  <= 2'b00;
        end else begin
            reqStart <= !nTsCpu;            // One pulse per strobe
            if (!nTsCpu) begin
                reqWrite <= !rnw;           // Stored as write flag
                reqSize  <= sizeMapped;
                reqAddr  <= addr;
            end
        end
    end

    // Write payload, only meaningful for writes
    always_ff @(posedge BCLK) begin
        if (!nTsCpu) begin
            reqWrData <= cpuWrData;         // Held until the next request
        end
    end

    // Attributes stay stable for the whole transfer
    // CPU may not start again before nTa

endmodule

/* rtl/portSequencer.sv */
// Port cycle FSM: nTs generation, DSACK sampling and longword split on a word port
`timescale 1ns/1ps

module portSequencer (
    input  logic       BCLK,
    input  logic       nRESET,
    input  logic       reqStart,      // New request held by decode
    input  logic       reqWrite,
    input  logic [1:0] reqSize,
    input  logic [1:0] dsack,         // Port termination code
    output logic       nTs,           // Port transfer start
    output logic [1:0] aOut,          // Port address bits 1:0
    output logic       portRnw,
    output logic       wordCapture,   // Pulse after first half of a split read
    output logic       lowerPhase,    // Second cycle of a split
    output logic       wordPort,      // Width from the last termination
    output logic       cycleDone      // Pulse after the final termination
);

    ////////////////////
    // State encoding
    ////////////////////

    typedef enum logic [1:0] {
        idle      = 2'b00,    // No port cycle running
        waitAck   = 2'b01,    // First or only cycle, waiting for DSACK
        lowerWord = 2'b10     // Lower half of a longword on a word port
    } seqState_t;

    seqState_t state;

    ////////////////////
    // Termination decode
    ////////////////////

    logic ackSeen;      // Valid DSACK after the strobe cycle
    logic splitNeeded;  // Longword met a word port

    // DSACK is ignored while nTs is still low
    assign ackSeen     = nTs && (dsack != busSizePkg::dsackWait);
    assign splitNeeded = (reqSize == busSizePkg::sizeLword) &&
                         (dsack == busSizePkg::dsackWord);

    assign lowerPhase = (state == lowerWord);

    ////////////////////
    // Cycle FSM
    ////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            state       <= idle;
            nTs         <= 1'b1;
            aOut        <= busSizePkg::portUpperWord;
            portRnw     <= 1'b1;
            wordCapture <= 1'b0;
            wordPort    <= 1'b0;
            cycleDone   <= 1'b0;
        end else begin
            // Strobes and pulses last one cycle
            nTs         <= 1'b1;
            wordCapture <= 1'b0;
            cycleDone   <= 1'b0;

            case (state)
                idle: begin
                    if (reqStart) begin
                        nTs     <= 1'b0;                        // Start first port cycle
                        aOut    <= busSizePkg::portUpperWord;
                        portRnw <= !reqWrite;
                        state   <= waitAck;
                    end
                end

                waitAck: begin
                    if (ackSeen) begin
                        wordPort <= (dsack == busSizePkg::dsackWord);
                        if (splitNeeded) begin
                            // Upper half done, run the lower half at offset 2
                            nTs         <= 1'b0;
                            aOut        <= busSizePkg::portLowerWord;
                            wordCapture <= !reqWrite;           // Only reads keep the word
                            state       <= lowerWord;
                        end else begin
                            cycleDone <= 1'b1;                  // Single cycle complete
                            state     <= idle;
                        end
                    end
                end

                lowerWord: begin
                    if (ackSeen) begin
                        wordPort  <= (dsack == busSizePkg::dsackWord);
                        aOut      <= busSizePkg::portUpperWord; // Park address
                        cycleDone <= 1'b1;
                        state     <= idle;
                    end
                end

                default: state <= idle;
            endcase
        end
    end

    // A held dsackWait keeps the FSM in place
    // Any number of wait states is allowed

endmodule

/* rtl/dataSteer.sv */
// Byte-lane steering for writes, read assembly from the port and the CPU acknowledge
`timescale 1ns/1ps

module dataSteer (
    input  logic                                BCLK,
    input  logic                                nRESET,
    input  logic                                reqWrite,
    input  logic [1:0]                          reqAddr,
    input  logic [busSizePkg::cpuDataWidth-1:0] reqWrData,
    input  logic [busSizePkg::cpuDataWidth-1:0] portRdData,
    input  logic                                wordCapture,  // First half of split read
    input  logic                                lowerPhase,
    input  logic                                wordPort,
    input  logic                                cycleDone,
    output logic [busSizePkg::cpuDataWidth-1:0] portWrData,
    output logic [busSizePkg::cpuDataWidth-1:0] cpuRdData,    // Valid while nTa is low
    output logic                                nTa
);

    ////////////////////
    // Write lanes
    ////////////////////

    logic [busSizePkg::wordWidth-1:0] cpuUpperWord;
    logic [busSizePkg::wordWidth-1:0] cpuLowerWord;
    logic [busSizePkg::wordWidth-1:0] wrUpperLane;

    assign cpuUpperWord = reqWrData[busSizePkg::cpuDataWidth-1:busSizePkg::wordWidth];
    assign cpuLowerWord = reqWrData[busSizePkg::wordWidth-1:0];

    // Upper port lanes also feed a word port
    assign wrUpperLane = (lowerPhase || reqAddr[1]) ? cpuLowerWord : cpuUpperWord;

    assign portWrData = {wrUpperLane, cpuLowerWord};    // Lower lanes always lower word

    ////////////////////
    // Read assembly
    ////////////////////

    logic [busSizePkg::cpuDataWidth-1:0] rdLatch;     // Port data at the last edge
    logic [busSizePkg::wordWidth-1:0]    upperHold;   // First word of a split read
    logic [busSizePkg::wordWidth-1:0]    portWord;    // Word-port lane
    logic [busSizePkg::cpuDataWidth-1:0] rdAssembled;
    logic                                splitRead;   // Upper half already captured

    assign portWord = rdLatch[busSizePkg::cpuDataWidth-1:busSizePkg::wordWidth];

    always_comb begin
        if (splitRead) begin
            rdAssembled = {upperHold, portWord};            // Two halves joined
        end else if (wordPort) begin
            // Word lands in the lane pair of the addressed word
            if (reqAddr[1]) begin
                rdAssembled = {{busSizePkg::wordWidth{1'b0}}, portWord};
            end else begin
                rdAssembled = {portWord, {busSizePkg::wordWidth{1'b0}}};
            end
        end else begin
            rdAssembled = rdLatch;                          // Long port straight through
        end
    end

    // Payload registers
    always_ff @(posedge BCLK) begin
        rdLatch <= portRdData;                              // Aligns data with the pulses
        if (wordCapture) begin
            upperHold <= portWord;
        end
        if (cycleDone && !reqWrite) begin
            cpuRdData <= rdAssembled;
        end
    end

    ////////////////////
    // Acknowledge
    ////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            splitRead <= 1'b0;
            nTa       <= 1'b1;
        end else begin
            nTa <= !cycleDone;                              // One low cycle per transfer
            if (wordCapture) begin
                splitRead <= 1'b1;
            end else if (cycleDone) begin
                splitRead <= 1'b0;                          // Ready for next request
            end
        end
    end

endmodule

/* rtl/busSizeBridge.sv */
// Bridge top level: request decode, port sequencer and data steering instances
`timescale 1ns/1ps

module busSizeBridge (
    input  logic                                BCLK,
    input  logic                                nRESET,
    // CPU side
    input  logic                                nTsCpu,
    input  logic                                rnw,
    input  logic [1:0]                          siz,
    input  logic [1:0]                          addr,
    input  logic [busSizePkg::cpuDataWidth-1:0] cpuWrData,
    output logic                                nTa,
    output logic [busSizePkg::cpuDataWidth-1:0] cpuRdData,
    // Port side
    output logic                                nTs,
    output logic [1:0]                          aOut,
    output logic                                portRnw,
    output logic [busSizePkg::cpuDataWidth-1:0] portWrData,
    input  logic [1:0]                          dsack,
    input  logic [busSizePkg::cpuDataWidth-1:0] portRdData
);

    ////////////////////
    // Internal wires
    ////////////////////

    logic                                reqStart;
    logic                                reqWrite;
    logic [1:0]                          reqSize;
    logic [1:0]                          reqAddr;
    logic [busSizePkg::cpuDataWidth-1:0] reqWrData;
    logic                                wordCapture;
    logic                                lowerPhase;
    logic                                wordPort;
    logic                                cycleDone;

    // Request capture
    cycleDecode decode (
        .BCLK, .nRESET, .nTsCpu, .rnw, .siz, .addr, .cpuWrData,
        .reqStart, .reqWrite, .reqSize, .reqAddr, .reqWrData
    );

    // Port cycles
    portSequencer execute (
        .BCLK, .nRESET, .reqStart, .reqWrite, .reqSize, .dsack,
        .nTs, .aOut, .portRnw, .wordCapture, .lowerPhase, .wordPort, .cycleDone
    );

    // Lanes and acknowledge
    dataSteer result (
        .BCLK, .nRESET, .reqWrite, .reqAddr, .reqWrData, .portRdData,
        .wordCapture, .lowerPhase, .wordPort, .cycleDone,
        .portWrData, .cpuRdData, .nTa
    );

endmodule

/* testbench/busSizeBridge_assert.sv */
// Concurrent checks on the port strobe, the CPU acknowledge and the port address, with bind
`timescale 1ns/1ps

module busSizeBridgeAssert (
    input logic       BCLK,
    input logic       nRESET,
    input logic       nTs,
    input logic       nTa,
    input logic [1:0] aOut
);

    logic strobeSeen;   // Port strobe issued since the last acknowledge

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            strobeSeen <= 1'b0;
        end else if (!nTs) begin
            strobeSeen <= 1'b1;
        end else if (!nTa) begin
            strobeSeen <= 1'b0;         // Transfer closed
        end
    end

    ////////////////////
    // Strobe widths
    ////////////////////

    tsSingle: assert property (@(posedge BCLK) disable iff (!nRESET) !nTs |=> nTs)
        else $error("nTs low for two consecutive cycles");

    taSingle: assert property (@(posedge BCLK) disable iff (!nRESET) !nTa |=> nTa)
        else $error("nTa low for two consecutive cycles");

    // Ordering and address
    taAfterTs: assert property (@(posedge BCLK) disable iff (!nRESET) !nTa |-> strobeSeen)
        else $error("nTa without a preceding nTs");

    // First strobe of a transfer at the upper word and a second one at the lower word
    aOutOrder: assert property (@(posedge BCLK) disable iff (!nRESET)
        !nTs |-> (aOut == (strobeSeen ? busSizePkg::portLowerWord
                                      : busSizePkg::portUpperWord)))
        else $error("aOut does not match the strobe order");

endmodule

bind busSizeBridge busSizeBridgeAssert checks (.BCLK, .nRESET, .nTs, .nTa, .aOut);

/* testbench/busSizeBridgeTb.sv */
// Testbench with clock, reset, port model, stimulus table, checks and timeout for the bridge
`timescale 1ns/1ps

module busSizeBridgeTb;

    localparam int rowCount     = 16;
    localparam int maxWait      = 4;                                  // Longest wait in the table
    localparam int timeoutLimit = rowCount * 2 * (maxWait + 4) + 4 + 100;  // Reset plus margin
    localparam logic [31:0] idleData = 32'h5A5A_A5A5;                 // Port bus outside an ack

    typedef struct packed {
        logic                                read;
        logic [1:0]                          size;
        logic [1:0]                          offset;      // CPU address bits 1:0
        logic                                longPort;    // Port answers dsackLong
        logic [2:0]                          waits;       // Wait states per port cycle
        logic [busSizePkg::cpuDataWidth-1:0] firstData;   // Port read data, first cycle
        logic [busSizePkg::cpuDataWidth-1:0] secondData;  // Port read data, second cycle
        logic [busSizePkg::cpuDataWidth-1:0] expRead;     // Expected cpuRdData
    } stimRow_t;

    logic                                BCLK;
    logic                                nRESET;
    logic                                nTsCpu;
    logic                                rnw;
    logic [1:0]                          siz;
    logic [1:0]                          addr;
    logic [busSizePkg::cpuDataWidth-1:0] cpuWrData;
    logic                                nTa;
    logic [busSizePkg::cpuDataWidth-1:0] cpuRdData;
    logic                                nTs;
    logic [1:0]                          aOut;
    logic                                portRnw;
    logic [busSizePkg::cpuDataWidth-1:0] portWrData;
    logic [1:0]                          dsack;
    logic [busSizePkg::cpuDataWidth-1:0] portRdData;

    stimRow_t                            stimTable [rowCount];
    stimRow_t                            row;                 // Row the port model serves
    logic [6:0]                          lfsr = 7'd63;
    int                                  errors = 0;
    int                                  cycleCount = 0;
    int                                  portCycles = 0;      // nTs strobes seen this row
    int                                  termsGiven = 0;      // Terminations driven this row
    int                                  expectedTerms = 0;
    int                                  taCount = 0;
    logic [1:0]                          seenAddr  [2];
    logic [busSizePkg::wordWidth-1:0]    seenUpper [2];       // Word-port lane per cycle
    logic [busSizePkg::cpuDataWidth-1:0] seenFull  [2];
    logic                                seenRnw   [2];

    busSizeBridge uut (
        .BCLK, .nRESET, .nTsCpu, .rnw, .siz, .addr, .cpuWrData, .nTa, .cpuRdData,
        .nTs, .aOut, .portRnw, .portWrData, .dsack, .portRdData
    );

    initial begin
        BCLK = 1'b0;
        forever #5 BCLK = ~BCLK;                // 10 ns period
    end

    ////////////////////
    // Helpers
    ////////////////////

    // 7-bit Fibonacci LFSR with taps 7 and 6
    function automatic logic [6:0] lfsrNext(input logic [6:0] state);
        lfsrNext = {state[5:0], state[6] ^ state[5]};
    endfunction

    task automatic drawWord(output logic [31:0] word);
        word = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsrNext(lfsr);              // One step per bit
            word = {word[30:0], lfsr[0]};
        end
    endtask

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] expected);
        errors++;
        $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, expected);
    endtask

    // read, size, offset, longPort, waits, firstData, secondData, expRead
    task automatic loadTable();
        logic [1:0] lw;
        logic [1:0] by;
        logic [1:0] wd;
        lw = busSizePkg::sizeLword;
        by = busSizePkg::sizeByte;
        wd = busSizePkg::sizeWord;
        stimTable[0]  = '{1'b1, lw, 2'd0, 1'b1, 3'd0, 32'h1122_3344, 32'h0, 32'h1122_3344};
        stimTable[1]  = '{1'b0, lw, 2'd0, 1'b1, 3'd2, 32'h0, 32'h0, 32'h0};
        stimTable[2]  = '{1'b1, lw, 2'd0, 1'b0, 3'd1, 32'hA1B2_5A5A, 32'hC3D4_A5A5, 32'hA1B2_C3D4};
        stimTable[3]  = '{1'b0, lw, 2'd0, 1'b0, 3'd0, 32'h0, 32'h0, 32'h0};
        stimTable[4]  = '{1'b1, wd, 2'd2, 1'b0, 3'd3, 32'h55AA_1234, 32'h0, 32'h0000_55AA};
        stimTable[5]  = '{1'b1, wd, 2'd0, 1'b0, 3'd0, 32'h6789_FFFF, 32'h0, 32'h6789_0000};
        stimTable[6]  = '{1'b1, by, 2'd3, 1'b0, 3'd1, 32'h00EE_1111, 32'h0, 32'h0000_00EE};
        stimTable[7]  = '{1'b1, by, 2'd1, 1'b0, 3'd2, 32'h3C00_2222, 32'h0, 32'h3C00_0000};
        stimTable[8]  = '{1'b0, wd, 2'd2, 1'b0, 3'd1, 32'h0, 32'h0, 32'h0};
        stimTable[9]  = '{1'b0, by, 2'd0, 1'b0, 3'd4, 32'h0, 32'h0, 32'h0};
        stimTable[10] = '{1'b1, lw, 2'd0, 1'b1, 3'd4, 32'hDEAD_BEEF, 32'h0, 32'hDEAD_BEEF};
        stimTable[11] = '{1'b1, lw, 2'd0, 1'b0, 3'd3, 32'h0BAD_1357, 32'hF00D_2468, 32'h0BAD_F00D};
        stimTable[12] = '{1'b0, lw, 2'd0, 1'b0, 3'd4, 32'h0, 32'h0, 32'h0};
        stimTable[13] = '{1'b1, wd, 2'd2, 1'b1, 3'd0, 32'hCAFE_BABE, 32'h0, 32'hCAFE_BABE};
        // Line size code folds onto a longword
        stimTable[14] = '{1'b1, 2'b11, 2'd0, 1'b0, 3'd2, 32'h1357_0000, 32'h9BDF_0000, 32'h1357_9BDF};
        stimTable[15] = '{1'b0, wd, 2'd0, 1'b1, 3'd1, 32'h0, 32'h0, 32'h0};
    endtask

    ////////////////////
    // Port model
    ////////////////////

    initial begin
        dsack      <= busSizePkg::dsackWait;
        portRdData <= idleData;
        forever begin
            @(posedge BCLK);
            if (nRESET === 1'b1 && nTs === 1'b0) begin
                if (portCycles < 2) begin
                    seenAddr[portCycles[0]]  = aOut;
                    seenUpper[portCycles[0]] = portWrData[31:16];  // Word-port lane
                    seenFull[portCycles[0]]  = portWrData;
                    seenRnw[portCycles[0]]   = portRnw;
                end
                portCycles++;
                repeat (row.waits) @(posedge BCLK);                // dsackWait held meanwhile
                dsack      <= row.longPort ? busSizePkg::dsackLong : busSizePkg::dsackWord;
                portRdData <= (portCycles == 1) ? row.firstData : row.secondData;
                termsGiven++;
                @(posedge BCLK);
                dsack      <= busSizePkg::dsackWait;
                portRdData <= idleData;
            end
        end
    end

    // Every nTa must follow the last termination of its request
    always @(posedge BCLK) begin
        if (nRESET === 1'b1 && nTa === 1'b0) begin
            taCount++;
            if (termsGiven != expectedTerms) begin
                reportMismatch("terminations before nTa", termsGiven, expectedTerms);
            end
        end
    end

    always @(posedge BCLK) begin
        cycleCount++;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic applyRow(input int idx);
        stimRow_t                            r;
        logic [busSizePkg::cpuDataWidth-1:0] wr;
        logic [busSizePkg::cpuDataWidth-1:0] mask;
        logic [busSizePkg::wordWidth-1:0]    firstUpper;
        logic                                isLong;
        int                                  expCycles;
        r = stimTable[idx];
        drawWord(wr);
        isLong     = (r.size != busSizePkg::sizeByte) && (r.size != busSizePkg::sizeWord);
        expCycles  = (isLong && !r.longPort) ? 2 : 1;          // Longword on a word port splits
        mask       = isLong ? 32'hFFFF_FFFF : (r.offset[1] ? 32'h0000_FFFF : 32'hFFFF_0000);
        firstUpper = r.offset[1] ? wr[15:0] : wr[31:16];       // Addressed CPU word
        row           = r;
        expectedTerms = expCycles;
        portCycles    = 0;
        termsGiven    = 0;
        taCount       = 0;
        @(posedge BCLK);
        nTsCpu    <= 1'b0;
        rnw       <= r.read;
        siz       <= r.size;
        addr      <= r.offset;
        cpuWrData <= wr;
        @(posedge BCLK);
        nTsCpu    <= 1'b1;
        while (nTa !== 1'b0) begin
            @(posedge BCLK);
        end
        if (r.read && ((cpuRdData & mask) !== (r.expRead & mask))) begin
            reportMismatch($sformatf("row %0d cpuRdData", idx), cpuRdData & mask,
                           r.expRead & mask);
        end
        @(posedge BCLK);                                       // Counters settle
        if (taCount != 1) begin
            reportMismatch($sformatf("row %0d nTa count", idx), taCount, 1);
        end
        if (portCycles != expCycles) begin
            reportMismatch($sformatf("row %0d port cycles", idx), portCycles, expCycles);
        end
        if (seenAddr[0] !== busSizePkg::portUpperWord || seenRnw[0] !== r.read) begin
            reportMismatch($sformatf("row %0d first aOut and portRnw", idx),
                           32'({seenAddr[0], seenRnw[0]}),
                           32'({busSizePkg::portUpperWord, r.read}));
        end
        if (expCycles == 2 && seenAddr[1] !== busSizePkg::portLowerWord) begin
            reportMismatch($sformatf("row %0d second aOut", idx), 32'(seenAddr[1]),
                           32'(busSizePkg::portLowerWord));
        end
        if (!r.read && seenUpper[0] !== firstUpper) begin
            reportMismatch($sformatf("row %0d upper lanes", idx), 32'(seenUpper[0]),
                           32'(firstUpper));
        end
        if (!r.read && expCycles == 2 && seenUpper[1] !== wr[15:0]) begin
            reportMismatch($sformatf("row %0d lower-word lanes", idx), 32'(seenUpper[1]),
                           32'(wr[15:0]));
        end
        if (!r.read && isLong && r.longPort && seenFull[0] !== wr) begin
            reportMismatch($sformatf("row %0d portWrData", idx), seenFull[0], wr);
        end
    endtask

    initial begin
        nRESET    <= 1'b0;
        nTsCpu    <= 1'b1;
        rnw       <= 1'b1;
        siz       <= busSizePkg::sizeLword;
        addr      <= 2'b00;
        cpuWrData <= '0;
        loadTable();
        repeat (4) @(posedge BCLK);
        nRESET <= 1'b1;
        // Quiet bus before the first request
        repeat (3) begin
            @(posedge BCLK);
            if (nTs !== 1'b1 || nTa !== 1'b1 || aOut !== 2'b00) begin
                reportMismatch("idle nTs, nTa and aOut", 32'({nTs, nTa, aOut}), 32'h0000_000C);
            end
        end
        for (int i = 0; i < rowCount; i++) begin
            applyRow(i);
        end
        @(posedge BCLK);
        $display("Finished %0d rows with %0d errors", rowCount, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* project.f */
rtl/busSizePkg.sv
rtl/cycleDecode.sv
rtl/portSequencer.sv
rtl/dataSteer.sv
rtl/busSizeBridge.sv
testbench/busSizeBridge_assert.sv
testbench/busSizeBridgeTb.sv

/* run.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module busSizeBridgeTb \
    -f project.f > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/VbusSizeBridgeTb > sim.log 2>&1 || echo "Some tests failed" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
echo "Simulation PASSED"
exit 0
